//--- hdl/ifetch_pkg.sv
`default_nettype none

package ifetch_pkg;

	// buffer organisation
	localparam int NUM_PAIRS = 2;	// ping-pong depends on exactly two pairs

	typedef logic [31:0] address_t;	// byte address of an instruction
	typedef logic [31:0] instruction_t;	// one raw instruction word
	typedef logic [$clog2(NUM_PAIRS)-1:0] pair_idx_t;	// selects a buffer pair

	// address arithmetic
	localparam address_t INSN_LEN = 32'd4;	// bytes per instruction
	localparam address_t FETCH_STEP = 32'd8;	// two instructions per fetch

	// boot vector
	localparam address_t RESET_PC = 32'hFFFD0000;

endpackage

`default_nettype wire

//--- hdl/fetch_pair_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_pair_if import ifetch_pkg::*;;

	// fill side, driven by the pc controller
	logic load;	// one-cycle strobe, fills both slots
	instruction_t instr0;
	instruction_t instr1;
	address_t base_pc;	// pc of slot 0, slot 1 derives its own

	// drain side, driven by the issue selector
	logic clr0;	// slot 0 dequeued this cycle
	logic clr1;

	// pair state
	logic v0;
	logic v1;
	instruction_t slot0_instr;
	instruction_t slot1_instr;
	address_t slot0_pc;
	address_t slot1_pc;

	modport feed (output load, instr0, instr1, base_pc, input v0, v1);

	// the pair itself
	modport buffer (
		input load, instr0, instr1, base_pc, clr0, clr1,
		output v0, v1, slot0_instr, slot1_instr, slot0_pc, slot1_pc
	);

	modport drain (
		output clr0, clr1,
		input v0, v1, slot0_instr, slot1_instr, slot0_pc, slot1_pc
	);

endinterface

`default_nettype wire

//--- hdl/fetch_buffer_pair.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer_pair import ifetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic branchmiss,	// flushes both slots
	fetch_pair_if.buffer pair
);

	logic v0_q;
	logic v1_q;
	instruction_t instr0_q;
	instruction_t instr1_q;
	address_t base_pc_q;	// slot 0 pc, slot 1 is one insn further

	// valid bits, flush > load > per-slot drain
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			v0_q <= 1'b0;
			v1_q <= 1'b0;
		end
		else if (branchmiss) begin
			v0_q <= 1'b0;
			v1_q <= 1'b0;
		end
		else if (pair.load) begin
			v0_q <= 1'b1;
			v1_q <= 1'b1;
		end
		else begin
			if (pair.clr0)
				v0_q <= 1'b0;	// slot 0 went to the queue
			if (pair.clr1)
				v1_q <= 1'b0;
		end
	end

	// payload only moves on a load
	always_ff @(posedge clk) begin
		if (pair.load) begin
			instr0_q <= pair.instr0;
			instr1_q <= pair.instr1;
			base_pc_q <= pair.base_pc;
		end
	end

	assign pair.v0 = v0_q;
	assign pair.v1 = v1_q;
	assign pair.slot0_instr = instr0_q;
	assign pair.slot1_instr = instr1_q;
	assign pair.slot0_pc = base_pc_q;
	assign pair.slot1_pc = base_pc_q + INSN_LEN;	// second word of the fetch

endmodule

`default_nettype wire

//--- hdl/fetch_pc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_ctrl import ifetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic hit,	// icache returned both words this cycle
	input logic irq,	// load but hold pc
	input logic branchmiss,
	input address_t misspc,
	input instruction_t inst0,
	input instruction_t inst1,
	output address_t pc,
	output logic stall,
	fetch_pair_if.feed pairs [NUM_PAIRS]
);

	logic [NUM_PAIRS-1:0] empty;	// both slots of a pair invalid
	logic any_empty;
	pair_idx_t load_idx;	// lowest empty pair
	logic do_load;

	for (genvar i = 0; i < NUM_PAIRS; i++) begin : g_pair
		assign empty[i] = ~pairs[i].v0 & ~pairs[i].v1;

		// fetched words and pc are broadcast, only the strobe is per pair
		assign pairs[i].load = do_load & (load_idx == pair_idx_t'(i));
		assign pairs[i].instr0 = inst0;
		assign pairs[i].instr1 = inst1;
		assign pairs[i].base_pc = pc;
	end

	// priority pick, walk downwards so pair 0 wins
	always_comb begin
		load_idx = '0;
		any_empty = 1'b0;
		for (int i = NUM_PAIRS - 1; i >= 0; i--) begin
			if (empty[i]) begin
				load_idx = pair_idx_t'(i);
				any_empty = 1'b1;
			end
		end
	end

	assign do_load = hit & ~branchmiss & any_empty;	// mispredict wins over a fetch

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			pc <= RESET_PC;
		end
		else if (branchmiss) begin
			pc <= misspc;	// redirect to the corrected target
		end
		else if (do_load && !irq) begin
			pc <= pc + FETCH_STEP;
		end
	end

	// stall for one cycle when a hit finds no room
	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			stall <= 1'b0;
		else
			stall <= hit & ~branchmiss & ~any_empty;
	end

endmodule

`default_nettype wire

//--- hdl/fetch_issue_sel.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_issue_sel import ifetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic hit,
	input logic branchmiss,
	input logic iq_free0,	// queue tail0 slot can accept
	input logic iq_free1,	// tail1, only counts when tail0 is free too
	fetch_pair_if.drain pairs [NUM_PAIRS],
	output instruction_t fetchbuf0_instr,
	output logic fetchbuf0_v,
	output address_t fetchbuf0_pc,
	output instruction_t fetchbuf1_instr,
	output logic fetchbuf1_v,
	output address_t fetchbuf1_pc
);

	pair_idx_t ptr;	// active pair, the one that feeds the queue

	// flattened view of all pairs
	logic [NUM_PAIRS-1:0] v0_all;
	logic [NUM_PAIRS-1:0] v1_all;
	instruction_t instr0_all [NUM_PAIRS];
	instruction_t instr1_all [NUM_PAIRS];
	address_t pc0_all [NUM_PAIRS];
	address_t pc1_all [NUM_PAIRS];

	logic act_v0;
	logic act_v1;
	logic deq0;	// dequeue slot 0 of the active pair
	logic deq1;
	logic flip;	// active pair is drained after this cycle
	logic all_empty;

	for (genvar i = 0; i < NUM_PAIRS; i++) begin : g_pair
		assign v0_all[i] = pairs[i].v0;
		assign v1_all[i] = pairs[i].v1;
		assign instr0_all[i] = pairs[i].slot0_instr;
		assign instr1_all[i] = pairs[i].slot1_instr;
		assign pc0_all[i] = pairs[i].slot0_pc;
		assign pc1_all[i] = pairs[i].slot1_pc;

		// clear strobes only reach the active pair
		assign pairs[i].clr0 = deq0 & (ptr == pair_idx_t'(i));
		assign pairs[i].clr1 = deq1 & (ptr == pair_idx_t'(i));
	end

	assign act_v0 = v0_all[ptr];
	assign act_v1 = v1_all[ptr];
	assign all_empty = ~|{v0_all, v1_all};

	// dequeue table, nothing moves unless tail0 is free
	always_comb begin
		deq0 = 1'b0;
		deq1 = 1'b0;
		flip = 1'b0;
		if (iq_free0 && !branchmiss) begin
			case ({act_v0, act_v1})
				2'b11: begin
					deq0 = 1'b1;
					deq1 = iq_free1;	// both go only if tail1 is free as well
					flip = iq_free1;
				end
				2'b10: begin
					deq0 = 1'b1;
					flip = 1'b1;
				end
				2'b01: begin
					deq1 = 1'b1;	// lone slot 1 goes into tail0
					flip = 1'b1;
				end
				default: ;	// active pair empty
			endcase
		end
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			ptr <= '0;
		else if (branchmiss)
			ptr <= '0;	// fetch restarts in pair 0
		else if (all_empty && hit)
			ptr <= '0;	// empty machine, next load lands in pair 0
		else if (flip)
			ptr <= ptr + 1'b1;
	end

	// steer the active pair to the queue
	assign fetchbuf0_instr = instr0_all[ptr];
	assign fetchbuf0_v = act_v0;
	assign fetchbuf0_pc = pc0_all[ptr];
	assign fetchbuf1_instr = instr1_all[ptr];
	assign fetchbuf1_v = act_v1;
	assign fetchbuf1_pc = pc1_all[ptr];

endmodule

`default_nettype wire

//--- hdl/ifetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_top import ifetch_pkg::*; (
	input logic clk,
	input logic rst,

	// icache side
	input logic hit,
	input logic irq,
	input instruction_t inst0,
	input instruction_t inst1,
	output address_t pc,
	output logic stall,

	// branch unit
	input logic branchmiss,
	input address_t misspc,

	// instruction queue side
	input logic iq_free0,
	input logic iq_free1,
	output instruction_t fetchbuf0_instr,
	output logic fetchbuf0_v,
	output address_t fetchbuf0_pc,
	output instruction_t fetchbuf1_instr,
	output logic fetchbuf1_v,
	output address_t fetchbuf1_pc
);

	fetch_pair_if pairs [NUM_PAIRS] ();	// one link per buffer pair

	// pc, load select, stall
	fetch_pc_ctrl u_ctrl (
		.clk (clk),
		.rst (rst),
		.hit (hit),
		.irq (irq),
		.branchmiss (branchmiss),
		.misspc (misspc),
		.inst0 (inst0),
		.inst1 (inst1),
		.pc (pc),
		.stall (stall),
		.pairs (pairs)
	);

	for (genvar i = 0; i < NUM_PAIRS; i++) begin : g_pair
		fetch_buffer_pair u_pair (
			.clk (clk),
			.rst (rst),
			.branchmiss (branchmiss),
			.pair (pairs[i])
		);
	end

	// ping-pong pointer and output mux
	fetch_issue_sel u_issue (
		.clk (clk),
		.rst (rst),
		.hit (hit),
		.branchmiss (branchmiss),
		.iq_free0 (iq_free0),
		.iq_free1 (iq_free1),
		.pairs (pairs),
		.fetchbuf0_instr (fetchbuf0_instr),
		.fetchbuf0_v (fetchbuf0_v),
		.fetchbuf0_pc (fetchbuf0_pc),
		.fetchbuf1_instr (fetchbuf1_instr),
		.fetchbuf1_v (fetchbuf1_v),
		.fetchbuf1_pc (fetchbuf1_pc)
	);

endmodule

`default_nettype wire

//--- sim/ifetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_tb import ifetch_pkg::*; ;

	localparam int COLS = 13;	// words per stimulus row
	localparam int MAX_ROWS = 64;
	localparam int CLK_HALF = 4;	// 8 ns period

	logic clk;
	logic rst;
	logic hit;
	logic irq;
	logic branchmiss;
	address_t misspc;
	instruction_t inst0;
	instruction_t inst1;
	logic iq_free0;
	logic iq_free1;
	address_t pc;
	logic stall;
	instruction_t fetchbuf0_instr;
	logic fetchbuf0_v;
	address_t fetchbuf0_pc;
	instruction_t fetchbuf1_instr;
	logic fetchbuf1_v;
	address_t fetchbuf1_pc;

	logic [31:0] stim [COLS*MAX_ROWS];	// flat copy of the input file
	int num_rows;
	logic loaded;	// file read, watchdog may start
	logic [31:0] lcg_state;
	instruction_t inflight [$];	// words held in the buffers, oldest first
	logic cur_v0;	// expected valids before the coming edge
	logic cur_v1;
	int test_errors;
	int tests_passed;
	int tests_failed;

	ifetch_top ifetch_top_i (
		.clk (clk),
		.rst (rst),
		.hit (hit),
		.irq (irq),
		.inst0 (inst0),
		.inst1 (inst1),
		.pc (pc),
		.stall (stall),
		.branchmiss (branchmiss),
		.misspc (misspc),
		.iq_free0 (iq_free0),
		.iq_free1 (iq_free1),
		.fetchbuf0_instr (fetchbuf0_instr),
		.fetchbuf0_v (fetchbuf0_v),
		.fetchbuf0_pc (fetchbuf0_pc),
		.fetchbuf1_instr (fetchbuf1_instr),
		.fetchbuf1_v (fetchbuf1_v),
		.fetchbuf1_pc (fetchbuf1_pc)
	);

	always #CLK_HALF clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;	// classic 32-bit lcg
	endfunction

	task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else begin
			$display("ERR %s expected %h got %h", name, exp, act);
			test_errors++;
		end
	endtask

	// drive one row and advance the model of the buffered stream
	task automatic apply_row(input int r);
		int b;
		int pops;
		b = r * COLS;
		hit = stim[b+1][0];
		irq = stim[b+2][0];
		branchmiss = stim[b+3][0];
		misspc = stim[b+4];
		iq_free0 = stim[b+5][0];
		iq_free1 = stim[b+6][0];
		lcg_state = lcg_next(lcg_state);
		inst0 = lcg_state;
		lcg_state = lcg_next(lcg_state);
		inst1 = lcg_state;
		pops = 0;
		if (branchmiss) begin
			inflight.delete();	// flush drops everything in flight
		end
		else begin
			if (iq_free0 && cur_v0 && cur_v1)
				pops = iq_free1 ? 2 : 1;
			else if (iq_free0 && (cur_v0 || cur_v1))
				pops = 1;	// lone slot always goes
			repeat (pops) if (inflight.size() > 0) void'(inflight.pop_front());
			if (hit && !stim[b+8][0]) begin	// a hit that does not stall loads a pair
				inflight.push_back(inst0);
				inflight.push_back(inst1);
			end
		end
		cur_v0 = stim[b+9][0];
		cur_v1 = stim[b+11][0];
	endtask

	task automatic verify_row(input int r);
		int b;
		int idx;
		b = r * COLS;
		compare_word("pc", stim[b+7], pc);
		compare_word("stall", stim[b+8], {31'b0, stall});
		compare_word("fetchbuf0_v", stim[b+9], {31'b0, fetchbuf0_v});
		compare_word("fetchbuf1_v", stim[b+11], {31'b0, fetchbuf1_v});
		if (stim[b+9][0]) begin
			compare_word("fetchbuf0_pc", stim[b+10], fetchbuf0_pc);
			assert (inflight.size() > 0)
			else begin
				$display("row %0d: no fetched word left to compare with fetchbuf0", r);
				test_errors++;
			end
			if (inflight.size() > 0)
				compare_word("fetchbuf0_instr", inflight[0], fetchbuf0_instr);
		end
		if (stim[b+11][0]) begin
			compare_word("fetchbuf1_pc", stim[b+12], fetchbuf1_pc);
			idx = stim[b+9][0] ? 1 : 0;	// slot 1 is oldest once slot 0 left
			assert (inflight.size() > idx)
			else begin
				$display("row %0d: no fetched word left to compare with fetchbuf1", r);
				test_errors++;
			end
			if (inflight.size() > idx)
				compare_word("fetchbuf1_instr", inflight[idx], fetchbuf1_instr);
		end
	endtask

	task automatic report_test(input logic [31:0] num);
		if (test_errors == 0) begin
			$display("test %0d passed", num);
			tests_passed++;
		end
		else begin
			$display("test %0d failed with %0d errors", num, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		hit = 1'b0;
		irq = 1'b0;
		branchmiss = 1'b0;
		misspc = '0;
		inst0 = '0;
		inst1 = '0;
		iq_free0 = 1'b0;
		iq_free1 = 1'b0;
		loaded = 1'b0;
		lcg_state = 32'd25;	// seed
		cur_v0 = 1'b0;
		cur_v1 = 1'b0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int i = 0; i < COLS * MAX_ROWS; i++)
			stim[i] = '0;	// test number 0 marks the end
		$readmemh("sim/ifetch_input.txt", stim);
		num_rows = 0;
		while (num_rows < MAX_ROWS && stim[num_rows*COLS] != 0)
			num_rows++;
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int r = 0; r < num_rows; r++) begin
			apply_row(r);
			@(negedge clk);	// outputs settled after the rising edge
			verify_row(r);
			if (r == num_rows - 1 || stim[(r+1)*COLS] != stim[r*COLS])
				report_test(stim[r*COLS]);
		end
		assert (num_rows > 0)
		else begin
			$display("no stimulus rows found in sim/ifetch_input.txt");
			tests_failed++;
		end
		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// watchdog, one clock per row plus reset and margin
	initial begin
		wait (loaded);
		#((num_rows + 4) * 2 * CLK_HALF + 200);
		$display("timeout: run did not finish within %0d clock cycles", num_rows + 4);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
hdl/ifetch_pkg.sv
hdl/fetch_pair_if.sv
hdl/fetch_buffer_pair.sv
hdl/fetch_pc_ctrl.sv
hdl/fetch_issue_sel.sv
hdl/ifetch_top.sv
sim/ifetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the instruction-fetch testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module ifetch_tb \
	--Mdir obj_dir \
	-o ifetch_sim \
	-f flist.f

./obj_dir/ifetch_sim > sim.log 2>&1
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
	exit 0
else
	exit 1
fi

//--- sim/ifetch_input.txt
// test hit irq branchmiss misspc iq_free0 iq_free1 | after the next rising edge:
// pc stall fetchbuf0_v fetchbuf0_pc fetchbuf1_v fetchbuf1_pc
1 0 0 0 00000000 0 0 FFFD0000 0 0 00000000 0 00000000
2 1 0 0 00000000 1 1 FFFD0008 0 1 FFFD0000 1 FFFD0004
2 1 0 0 00000000 1 1 FFFD0010 0 1 FFFD0008 1 FFFD000C
2 1 0 0 00000000 1 1 FFFD0018 0 1 FFFD0010 1 FFFD0014
2 0 0 0 00000000 1 1 FFFD0018 0 0 00000000 0 00000000
2 1 0 0 00000000 1 1 FFFD0020 0 1 FFFD0018 1 FFFD001C
2 0 0 0 00000000 1 1 FFFD0020 0 0 00000000 0 00000000
3 1 0 0 00000000 1 0 FFFD0028 0 1 FFFD0020 1 FFFD0024
3 0 0 0 00000000 1 0 FFFD0028 0 0 00000000 1 FFFD0024
3 1 0 0 00000000 0 0 FFFD0030 0 0 00000000 1 FFFD0024
3 1 0 0 00000000 0 0 FFFD0030 1 0 00000000 1 FFFD0024
3 0 0 0 00000000 1 1 FFFD0030 0 1 FFFD0028 1 FFFD002C
3 0 0 0 00000000 1 0 FFFD0030 0 0 00000000 1 FFFD002C
3 0 0 0 00000000 1 1 FFFD0030 0 0 00000000 0 00000000
4 1 1 0 00000000 0 0 FFFD0030 0 1 FFFD0030 1 FFFD0034
4 1 1 0 00000000 0 0 FFFD0030 0 1 FFFD0030 1 FFFD0034
4 0 0 0 00000000 1 1 FFFD0030 0 1 FFFD0030 1 FFFD0034
4 1 0 0 00000000 1 1 FFFD0038 0 1 FFFD0030 1 FFFD0034
4 0 0 0 00000000 1 1 FFFD0038 0 0 00000000 0 00000000
5 1 0 0 00000000 0 0 FFFD0040 0 1 FFFD0038 1 FFFD003C
5 1 0 0 00000000 1 0 FFFD0048 0 0 00000000 1 FFFD003C
5 1 0 1 00001000 1 1 00001000 0 0 00000000 0 00000000
5 1 0 0 00000000 0 0 00001008 0 1 00001000 1 00001004
5 1 0 0 00000000 1 1 00001010 0 1 00001008 1 0000100C
5 0 0 0 00000000 1 1 00001010 0 0 00000000 0 00000000
